//--- filelist.f
+incdir+verification
hdl/exec_pkg.sv
hdl/alu_adder.sv
hdl/alu_shifter.sv
hdl/alu_decode.sv
hdl/alu_core.sv
hdl/exec_stage.sv
verification/exec_tb.sv

//--- hdl/alu_adder.sv
`timescale 1ns/1ps

module alu_adder (
    input  exec_pkg::word_t x,
    input  exec_pkg::word_t y,
    input  logic            cin,
    output exec_pkg::word_t sum,
    output logic            carry,
    output logic            overflow,
    output logic            zero,
    output logic            neg
);
    import exec_pkg::*;

    // one extra bit catches the carry out of the msb
    logic [xlen:0] full_sum;

    assign full_sum = {1'b0, x} + {1'b0, y} + {{xlen{1'b0}}, cin};

    assign sum   = full_sum[xlen-1:0];
    assign carry = full_sum[xlen];

    // y is already inverted for a subtraction, so this holds for both
    assign overflow = (x[xlen-1] == y[xlen-1]) && (sum[xlen-1] != x[xlen-1]);

    assign zero = ~(|sum);
    assign neg  = sum[xlen-1];

endmodule

//--- hdl/alu_core.sv
`timescale 1ns/1ps

module alu_core (
    input  logic                 clock,
    input  logic                 rst,
    input  logic                 op_valid,
    input  exec_pkg::alu_op_t    op,
    input  logic                 alt,
    input  exec_pkg::word_t      a,
    input  exec_pkg::word_t      b,
    output logic                 res_valid,
    output exec_pkg::word_t      value,
    output exec_pkg::alu_flags_t flags,
    output logic                 taken
);
    import exec_pkg::*;

    // registered operands
    word_t   a_q;
    word_t   b_q;
    alu_op_t op_q;
    logic    alt_q;

    // decoded controls
    unit_sel_t   unit;
    shift_kind_t shift_kind;
    logic        sub;
    logic        signed_cmp;
    logic        is_branch;
    logic        br_eq;
    logic        br_ne;
    logic        br_lt;
    logic        br_ge;

    // datapath results
    word_t adder_y;
    word_t sum;
    logic  carry;
    logic  overflow;
    logic  zero;
    logic  neg;
    word_t shifted;
    word_t logic_res;
    logic  less_than;

    always_ff @(posedge clock) begin
        if (rst) begin
            res_valid <= 1'b0;
        end else begin
            res_valid <= op_valid;
        end
    end

    always_ff @(posedge clock) begin
        if (op_valid) begin
            a_q   <= a;
            b_q   <= b;
            op_q  <= op;
            alt_q <= alt;
        end
    end

    alu_decode i_decode (
        .op         (op_q),
        .alt        (alt_q),
        .unit       (unit),
        .shift_kind (shift_kind),
        .sub        (sub),
        .signed_cmp (signed_cmp),
        .is_branch  (is_branch),
        .br_eq      (br_eq),
        .br_ne      (br_ne),
        .br_lt      (br_lt),
        .br_ge      (br_ge)
    );

    // a - b is a + ~b + 1
    assign adder_y = sub ? ~b_q : b_q;

    alu_adder i_adder (
        .x        (a_q),
        .y        (adder_y),
        .cin      (sub),
        .sum      (sum),
        .carry    (carry),
        .overflow (overflow),
        .zero     (zero),
        .neg      (neg)
    );

    alu_shifter i_shifter (
        .a       (a_q),
        .amount  (b_q[shamt_w-1:0]),
        .kind    (shift_kind),
        .shifted (shifted)
    );

    // low op bits pick the logic operator
    always_comb begin
        case (op_q[1:0])
            2'b10:   logic_res = a_q | b_q;
            2'b11:   logic_res = a_q & b_q;
            default: logic_res = a_q ^ b_q;
        endcase
    end

    // carry set means no borrow on a subtraction
    assign less_than = signed_cmp ? (overflow ^ neg) : ~carry;

    always_comb begin
        case (unit)
            unit_shift: value = shifted;
            unit_logic: value = logic_res;
            unit_cmp:   value = {{(xlen-1){1'b0}}, less_than};
            default:    value = sum;
        endcase
    end

    assign flags.zero     = zero;
    assign flags.carry    = carry;
    assign flags.overflow = overflow;

    assign taken = is_branch && ((br_eq && zero) || (br_ne && !zero) ||
                                 (br_lt && less_than) || (br_ge && !less_than));

    a_no_valid_after_reset: assert property (@(posedge clock) rst |=> !res_valid);

    // compare and branch codes must come out as a single result bit
    a_cmp_upper_zero: assert property (@(posedge clock) disable iff (rst)
        (res_valid && (op_q[3] || op_q inside {op_slt, op_sltu}))
            |-> (value[xlen-1:1] == '0));

    a_valid_from_issue: assert property (@(posedge clock) disable iff (rst)
        res_valid |-> $past(op_valid));

endmodule

//--- hdl/alu_decode.sv
`timescale 1ns/1ps

module alu_decode (
    input  exec_pkg::alu_op_t     op,
    input  logic                  alt,
    output exec_pkg::unit_sel_t   unit,
    output exec_pkg::shift_kind_t shift_kind,
    output logic                  sub,
    output logic                  signed_cmp,
    output logic                  is_branch,
    output logic                  br_eq,
    output logic                  br_ne,
    output logic                  br_lt,
    output logic                  br_ge
);
    import exec_pkg::*;

    always_comb begin
        unit       = unit_adder;
        shift_kind = shift_sll;
        sub        = 1'b0;
        signed_cmp = 1'b0;
        is_branch  = 1'b0;
        br_eq      = 1'b0;
        br_ne      = 1'b0;
        br_lt      = 1'b0;
        br_ge      = 1'b0;
        case (op)
            op_add:  sub = alt;
            op_sll:  unit = unit_shift;
            op_sr: begin
                unit       = unit_shift;
                shift_kind = alt ? shift_sra : shift_srl;
            end
            op_xor, op_or, op_and: unit = unit_logic;
            // compares and branches always go through a subtraction
            op_slt, op_sltu: begin
                unit       = unit_cmp;
                sub        = 1'b1;
                signed_cmp = (op == op_slt);
            end
            op_beq, op_bne, op_blt, op_bge, op_bltu, op_bgeu: begin
                unit       = unit_cmp;
                sub        = 1'b1;
                is_branch  = 1'b1;
                signed_cmp = (op == op_blt) || (op == op_bge);
                br_eq      = (op == op_beq);
                br_ne      = (op == op_bne);
                br_lt      = (op == op_blt) || (op == op_bltu);
                br_ge      = (op == op_bge) || (op == op_bgeu);
            end
            default: unit = unit_adder;
        endcase
    end

    // a defined op must land on a known unit, and only branch codes may flag a branch
    always_comb begin
        if (op inside {op_add, op_sll, op_slt, op_sltu, op_xor, op_sr, op_or, op_and,
                       op_beq, op_bne, op_blt, op_bge, op_bltu, op_bgeu}) begin
            assert (!$isunknown(unit) && (is_branch == (op[3] && unit == unit_cmp)));
        end
    end

endmodule

//--- hdl/alu_shifter.sv
`timescale 1ns/1ps

module alu_shifter (
    input  exec_pkg::word_t       a,
    input  exec_pkg::shamt_t      amount,
    input  exec_pkg::shift_kind_t kind,
    output exec_pkg::word_t       shifted
);
    import exec_pkg::*;

    function automatic word_t bit_reverse(input word_t w);
        word_t r;
        for (int i = 0; i < xlen; i++) begin
            r[i] = w[xlen-1-i];
        end
        return r;
    endfunction

    logic  fill;
    word_t stage [shamt_w+1];

    // left shift runs as a right shift on the mirrored word
    assign fill     = (kind == shift_sra) ? a[xlen-1] : 1'b0;
    assign stage[0] = (kind == shift_sll) ? bit_reverse(a) : a;

    for (genvar i = 0; i < shamt_w; i++) begin : g_level
        localparam int step = 1 << i;
        assign stage[i+1] = amount[i] ? {{step{fill}}, stage[i][xlen-1:step]} : stage[i];
    end

    assign shifted = (kind == shift_sll) ? bit_reverse(stage[shamt_w]) : stage[shamt_w];

endmodule

//--- hdl/exec_pkg.sv
package exec_pkg;

    // RV32I data path widths
    localparam int xlen    = 32;
    localparam int shamt_w = 5;

    typedef logic [xlen-1:0]    word_t;
    typedef logic [shamt_w-1:0] shamt_t;

    // operation codes, bit 3 marks a conditional branch
    typedef enum logic [3:0] {
        op_add  = 4'b0000,
        op_sll  = 4'b0001,
        op_slt  = 4'b0010,
        op_sltu = 4'b0011,
        op_xor  = 4'b0100,
        op_sr   = 4'b0101,
        op_or   = 4'b0110,
        op_and  = 4'b0111,
        op_beq  = 4'b1000,
        op_bne  = 4'b1001,
        op_blt  = 4'b1100,
        op_bge  = 4'b1101,
        op_bltu = 4'b1110,
        op_bgeu = 4'b1111
    } alu_op_t;

    // result path inside the ALU
    typedef enum logic [1:0] {
        unit_adder = 2'b00,
        unit_shift = 2'b01,
        unit_logic = 2'b10,
        unit_cmp   = 2'b11
    } unit_sel_t;

    typedef enum logic [1:0] {
        shift_sll = 2'b00,
        shift_srl = 2'b01,
        shift_sra = 2'b10
    } shift_kind_t;

    // one decoded instruction as seen by the execute stage
    typedef struct packed {
        alu_op_t op;
        logic    alt;      // subtract for add, arithmetic for sr
        logic    use_imm;
        word_t   rs1_val;
        word_t   rs2_val;
        word_t   imm;
        word_t   pc;
    } issue_t;

    typedef struct packed {
        logic zero;
        logic carry;
        logic overflow;
    } alu_flags_t;

    typedef struct packed {
        word_t      value;
        alu_flags_t flags;
        logic       taken;
        word_t      target;
    } exec_result_t;

endpackage

//--- hdl/exec_stage.sv
`timescale 1ns/1ps

module exec_stage (
    input  logic                   clock,
    input  logic                   rst,
    input  logic                   issue_valid,
    input  exec_pkg::issue_t       issue,
    output logic                   result_valid,
    output exec_pkg::exec_result_t result
);
    import exec_pkg::*;

    word_t      operand_b;
    word_t      target_next;
    word_t      target_q;
    word_t      alu_value;
    alu_flags_t alu_flags;
    logic       alu_taken;
    logic       alu_valid;

    // immediate forms replace rs2
    assign operand_b = issue.use_imm ? issue.imm : issue.rs2_val;

    // branch target, registered alongside the ALU operands
    assign target_next = issue.pc + issue.imm;

    always_ff @(posedge clock) begin
        if (issue_valid) begin
            target_q <= target_next;
        end
    end

    alu_core i_alu_core (
        .clock     (clock),
        .rst       (rst),
        .op_valid  (issue_valid),
        .op        (issue.op),
        .alt       (issue.alt),
        .a         (issue.rs1_val),
        .b         (operand_b),
        .res_valid (alu_valid),
        .value     (alu_value),
        .flags     (alu_flags),
        .taken     (alu_taken)
    );

    assign result_valid = alu_valid;

    assign result.value  = alu_value;
    assign result.flags  = alu_flags;
    assign result.taken  = alu_taken;
    assign result.target = target_q;

endmodule

//--- run_sim.sh
#!/bin/sh
# build the execute stage testbench with Verilator and run it
cd "$(dirname "$0")" &&
    verilator --binary --timing --assert --top-module exec_tb -f filelist.f -o exec_sim &&
    ./obj_dir/exec_sim | tee /dev/stderr | grep -q "SIMULATION PASSED" ||
    exit 1

//--- verification/exec_ref.svh
`ifndef EXEC_REF_SVH
`define EXEC_REF_SVH

// reference model of the execute stage, one function per result field

// operand b as the stage selects it
function automatic word_t second_operand(input issue_t iss);
    return iss.use_imm ? iss.imm : iss.rs2_val;
endfunction

// sub with alt, and every compare or branch
function automatic logic subtracts(input issue_t iss);
    return (iss.op == op_add && iss.alt) || iss.op[3] || iss.op == op_slt || iss.op == op_sltu;
endfunction

function automatic word_t expected_value(input issue_t iss);
    word_t a;
    word_t b;
    a = iss.rs1_val;
    b = second_operand(iss);
    case (iss.op)
        op_add:  return iss.alt ? a - b : a + b;
        op_sll:  return a << b[4:0];
        op_sr:   return iss.alt ? word_t'($signed(a) >>> b[4:0]) : a >> b[4:0];
        op_slt:  return {31'b0, $signed(a) < $signed(b)};
        op_sltu: return {31'b0, a < b};
        op_xor:  return a ^ b;
        op_or:   return a | b;
        op_and:  return a & b;
        default: return '0;
    endcase
endfunction

function automatic alu_flags_t expected_flags(input issue_t iss);
    word_t       a;
    word_t       b;
    logic [32:0] wide;
    alu_flags_t  f;
    a = iss.rs1_val;
    b = second_operand(iss);
    if (subtracts(iss)) begin
        // bit 32 is the borrow, carry reports its absence
        wide       = {1'b0, a} - {1'b0, b};
        f.carry    = ~wide[32];
        f.overflow = (a[31] != b[31]) && (wide[31] != a[31]);
    end else begin
        wide       = {1'b0, a} + {1'b0, b};
        f.carry    = wide[32];
        f.overflow = (a[31] == b[31]) && (wide[31] != a[31]);
    end
    f.zero = (wide[31:0] == 32'h0);
    return f;
endfunction

function automatic logic expected_taken(input issue_t iss);
    word_t a;
    word_t b;
    a = iss.rs1_val;
    b = second_operand(iss);
    case (iss.op)
        op_beq:  return a == b;
        op_bne:  return a != b;
        op_blt:  return $signed(a) < $signed(b);
        op_bge:  return $signed(a) >= $signed(b);
        op_bltu: return a < b;
        op_bgeu: return a >= b;
        default: return 1'b0;
    endcase
endfunction

function automatic word_t expected_target(input issue_t iss);
    return iss.pc + iss.imm;
endfunction

// branches only define taken and target
function automatic logic value_matters(input issue_t iss);
    return !iss.op[3];
endfunction

function automatic logic flags_matter(input issue_t iss);
    return iss.op == op_add || subtracts(iss);
endfunction

`endif

//--- verification/exec_tb.sv
`timescale 1ns/1ps

module exec_tb;
    import exec_pkg::*;

    `include "exec_ref.svh"

    typedef struct packed {
        exec_result_t res;
        logic         check_value;
        logic         check_flags;
    } expect_t;

    // issue and idle counts of the tests, bounding the run
    localparam int n_issues     = 64 + 40 + 36 + 16 + 30 + 15;
    localparam int n_idle       = 40;
    localparam int reset_cycles = 3;
    localparam int max_cycles   = (n_issues + n_idle) * 2 + reset_cycles;

    logic         clock;
    logic         rst;
    logic         issue_valid;
    issue_t       issue;
    logic         result_valid;
    exec_result_t result;

    expect_t      exp_queue [$];
    expect_t      exp_q;
    logic         exp_valid = 1'b0;
    logic         rst_q = 1'b0;
    logic [31:0]  lfsr_state = 32'h236f8e14;
    int           errors = 0;
    int           cycle_count = 0;
    int           tests_passed = 0;
    int           tests_failed = 0;

    initial clock = 1'b0;
    always #5 clock = ~clock;

    exec_stage i_dut (
        .clock        (clock),
        .rst          (rst),
        .issue_valid  (issue_valid),
        .issue        (issue),
        .result_valid (result_valid),
        .result       (result)
    );

    // the DUT takes an issue on this edge, so its expectation moves into the check slot
    always @(posedge clock) begin
        expect_t head;
        rst_q <= rst;
        if (rst) begin
            exp_valid <= 1'b0;
        end else begin
            exp_valid <= issue_valid;
            if (issue_valid && exp_queue.size() == 0) begin
                $display("issue accepted by the DUT with no expected result queued");
                errors++;
            end else if (issue_valid) begin
                head = exp_queue.pop_front();
                exp_q <= head;
            end
        end
    end

    a_low_after_reset: assert property (@(posedge clock) rst_q |-> !result_valid)
    else begin
        errors++;
        $display("result_valid high in the cycle after a reset edge");
    end

    a_valid_match: assert property (@(posedge clock) disable iff (rst)
        result_valid == exp_valid)
    else begin
        errors++;
        if ($sampled(exp_valid)) begin
            $display("missing result: result_valid low one cycle after an issue");
        end else begin
            $display("unexpected result: result_valid high without an issue");
        end
    end

    a_value_match: assert property (@(posedge clock) disable iff (rst)
        (result_valid && exp_valid && exp_q.check_value) |-> result.value == exp_q.res.value)
    else begin
        errors++;
        $display("Fail result.value: expected %h, got %h",
                 $sampled(exp_q.res.value), $sampled(result.value));
    end

    a_flags_match: assert property (@(posedge clock) disable iff (rst)
        (result_valid && exp_valid && exp_q.check_flags) |-> result.flags == exp_q.res.flags)
    else begin
        errors++;
        $display("Fail result.flags: expected %h, got %h",
                 $sampled(exp_q.res.flags), $sampled(result.flags));
    end

    a_taken_match: assert property (@(posedge clock) disable iff (rst)
        (result_valid && exp_valid) |-> result.taken == exp_q.res.taken)
    else begin
        errors++;
        $display("Fail result.taken: expected %h, got %h",
                 $sampled(exp_q.res.taken), $sampled(result.taken));
    end

    a_target_match: assert property (@(posedge clock) disable iff (rst)
        (result_valid && exp_valid) |-> result.target == exp_q.res.target)
    else begin
        errors++;
        $display("Fail result.target: expected %h, got %h",
                 $sampled(exp_q.res.target), $sampled(result.target));
    end

    always @(posedge clock) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= max_cycles) begin
            $display("timeout: run did not finish within %0d cycles", max_cycles);
            $display("SIMULATION FAILED");
            $finish;
        end
    end

    // galois lfsr, one step per bit handed out
    function automatic logic [31:0] random_bits(input int n);
        logic [31:0] r;
        logic        out_bit;
        r = '0;
        for (int i = 0; i < n; i++) begin
            out_bit = lfsr_state[0];
            lfsr_state = {1'b0, lfsr_state[31:1]};
            if (out_bit) begin
                lfsr_state = lfsr_state ^ 32'h80200003;
            end
            r = {r[30:0], out_bit};
        end
        return r;
    endfunction

    function automatic logic random_bit();
        logic [31:0] r;
        r = random_bits(1);
        return r[0];
    endfunction

    // b goes to imm or rs2 by use_imm, the unused one gets noise
    task automatic send(input alu_op_t op, input logic alt, input logic use_imm,
                        input word_t a, input word_t b);
        issue_t  iss;
        expect_t e;
        iss.op      = op;
        iss.alt     = alt;
        iss.use_imm = use_imm;
        iss.rs1_val = a;
        iss.rs2_val = use_imm ? random_bits(32) : b;
        iss.imm     = use_imm ? b : random_bits(32);
        iss.pc      = random_bits(32) & 32'hffff_fffc;
        e.res.value  = expected_value(iss);
        e.res.flags  = expected_flags(iss);
        e.res.taken  = expected_taken(iss);
        e.res.target = expected_target(iss);
        e.check_value = value_matters(iss);
        e.check_flags = flags_matter(iss);
        @(posedge clock);
        issue_valid <= 1'b1;
        issue       <= iss;
        exp_queue.push_back(e);
    endtask

    task automatic idle(input int cycles);
        repeat (cycles) begin
            @(posedge clock);
            issue_valid <= 1'b0;
        end
    endtask

    // rst held while issues keep arriving
    task automatic apply_reset(input int cycles);
        repeat (cycles) begin
            @(posedge clock);
            rst         <= 1'b1;
            issue_valid <= 1'b1;
        end
        @(posedge clock);
        rst         <= 1'b0;
        issue_valid <= 1'b0;
    endtask

    task automatic finish_test(input string name, input int errors_before);
        idle(3);
        if (errors == errors_before && exp_queue.size() == 0) begin
            tests_passed++;
            $display("test %s: ok", name);
        end else begin
            tests_failed++;
            $display("test %s: %0d errors, %0d results never seen", name,
                     errors - errors_before, exp_queue.size());
        end
    endtask

    task automatic run_add_sub();
        word_t corners [4];
        int    errors_before;
        corners = '{32'h0, 32'hffff_ffff, 32'h7fff_ffff, 32'h8000_0000};
        errors_before = errors;
        for (int i = 0; i < 4; i++) begin
            for (int j = 0; j < 4; j++) begin
                send(op_add, 1'b0, 1'b0, corners[i], corners[j]);
                send(op_add, 1'b1, 1'b0, corners[i], corners[j]);
            end
        end
        for (int i = 0; i < 16; i++) begin
            send(op_add, 1'b0, random_bit(), random_bits(32), random_bits(32));
            send(op_add, 1'b1, random_bit(), random_bits(32), random_bits(32));
        end
        finish_test("add_sub", errors_before);
    endtask

    task automatic run_shifts();
        int errors_before;
        errors_before = errors;
        for (int i = 0; i < 12; i++) begin
            send(op_sll, 1'b0, i[0], random_bits(32), random_bits(32));
            send(op_sr, 1'b0, i[0], random_bits(32), random_bits(32));
            send(op_sr, 1'b1, i[0], random_bits(32), random_bits(32));
        end
        // negative operands under sra, including the extreme amounts
        send(op_sr, 1'b1, 1'b0, random_bits(32) | 32'h8000_0000, 32'd0);
        send(op_sr, 1'b1, 1'b1, random_bits(32) | 32'h8000_0000, 32'd1);
        send(op_sr, 1'b1, 1'b0, 32'h8000_0000, 32'd31);
        send(op_sr, 1'b1, 1'b1, random_bits(32) | 32'h8000_0000, random_bits(32));
        finish_test("shifts", errors_before);
    endtask

    task automatic run_logic();
        int errors_before;
        errors_before = errors;
        for (int i = 0; i < 12; i++) begin
            send(op_xor, 1'b0, i[0], random_bits(32), random_bits(32));
            send(op_or, 1'b0, i[0], random_bits(32), random_bits(32));
            send(op_and, 1'b0, i[0], random_bits(32), random_bits(32));
        end
        finish_test("logic", errors_before);
    endtask

    // one operand negative, so signed and unsigned orderings disagree
    task automatic run_compare();
        word_t neg_val;
        word_t pos_val;
        int    errors_before;
        errors_before = errors;
        for (int i = 0; i < 8; i++) begin
            neg_val = random_bits(32) | 32'h8000_0000;
            pos_val = random_bits(32) & 32'h7fff_ffff;
            if (i[0]) begin
                send(op_slt, 1'b0, i[1], pos_val, neg_val);
                send(op_sltu, 1'b0, i[1], pos_val, neg_val);
            end else begin
                send(op_slt, 1'b0, i[1], neg_val, pos_val);
                send(op_sltu, 1'b0, i[1], neg_val, pos_val);
            end
        end
        finish_test("compare", errors_before);
    endtask

    task automatic run_branches();
        alu_op_t br_ops [6];
        word_t   small_val;
        word_t   big_val;
        word_t   neg_val;
        int      errors_before;
        br_ops = '{op_beq, op_bne, op_blt, op_bge, op_bltu, op_bgeu};
        errors_before = errors;
        for (int i = 0; i < 6; i++) begin
            small_val = random_bits(32) & 32'h3fff_ffff;
            big_val   = small_val + 32'd1 + (random_bits(32) & 32'hff);
            neg_val   = random_bits(32) | 32'h8000_0000;
            send(br_ops[i], 1'b0, 1'b0, small_val, small_val);
            send(br_ops[i], 1'b0, 1'b0, small_val, big_val);
            send(br_ops[i], 1'b0, 1'b0, big_val, small_val);
            send(br_ops[i], 1'b0, 1'b0, neg_val, big_val);
            send(br_ops[i], 1'b0, 1'b0, big_val, neg_val);
        end
        finish_test("branches", errors_before);
    endtask

    task automatic run_timing();
        alu_op_t all_ops [14];
        int      idx;
        int      errors_before;
        all_ops = '{op_add, op_sll, op_slt, op_sltu, op_xor, op_sr, op_or, op_and,
                    op_beq, op_bne, op_blt, op_bge, op_bltu, op_bgeu};
        errors_before = errors;
        for (int i = 0; i < 8; i++) begin
            idx = int'(random_bits(4)) % 14;
            send(all_ops[idx], random_bit(), random_bit(), random_bits(32), random_bits(32));
        end
        for (int i = 0; i < 6; i++) begin
            idx = int'(random_bits(4)) % 14;
            send(all_ops[idx], random_bit(), random_bit(), random_bits(32), random_bits(32));
            idle(2);
        end
        apply_reset(reset_cycles);
        send(op_add, 1'b1, 1'b0, random_bits(32), random_bits(32));
        finish_test("timing_reset", errors_before);
    endtask

    initial begin
        rst         = 1'b1;
        issue_valid = 1'b0;
        issue       = '0;
        repeat (reset_cycles) @(posedge clock);
        rst <= 1'b0;
        run_add_sub();
        run_shifts();
        run_logic();
        run_compare();
        run_branches();
        run_timing();
        $display("tests passed %0d, tests failed %0d, errors %0d",
                 tests_passed, tests_failed, errors);
        if (tests_failed == 0 && errors == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule
